//--- exec_pkg.sv
`default_nettype none

package exec_pkg;

  localparam int xlen = 32;
  localparam int iter_count = 32; // steps of mul and div.
  localparam int iter_bits = $clog2(iter_count);

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [4:0] op_t;
  typedef logic [3:0] strb_t;
  typedef logic [iter_bits-1:0] iter_cnt_t;

  // alu class.
  localparam op_t op_nop = 5'd0;
  localparam op_t op_add = 5'd1;
  localparam op_t op_sub = 5'd2;
  localparam op_t op_and = 5'd3;
  localparam op_t op_or = 5'd4;
  localparam op_t op_xor = 5'd5;
  localparam op_t op_sll = 5'd6;
  localparam op_t op_srl = 5'd7;
  localparam op_t op_sra = 5'd8;
  localparam op_t op_slt = 5'd9;
  localparam op_t op_sltu = 5'd10;
  localparam op_t op_lui = 5'd11;

  // iterative units.
  localparam op_t op_mul = 5'd12;
  localparam op_t op_mulhu = 5'd13;
  localparam op_t op_div = 5'd14;
  localparam op_t op_divu = 5'd15;
  localparam op_t op_rem = 5'd16;
  localparam op_t op_remu = 5'd17;

  // loads and stores.
  localparam op_t op_lb = 5'd18;
  localparam op_t op_lbu = 5'd19;
  localparam op_t op_lh = 5'd20;
  localparam op_t op_lhu = 5'd21;
  localparam op_t op_lw = 5'd22;
  localparam op_t op_sb = 5'd23;
  localparam op_t op_sh = 5'd24;
  localparam op_t op_sw = 5'd25;

  typedef enum logic [1:0] {
    iter_idle,
    iter_busy,
    iter_done
  } iter_state_t;

  typedef enum logic {
    mem_idle,
    mem_wait_ready
  } mem_state_t;

endpackage

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu (
  input wire exec_pkg::word_t a,
  input wire exec_pkg::word_t b,
  input wire exec_pkg::op_t op,
  output exec_pkg::word_t result
);

  always_comb begin
    case (op)
      exec_pkg::op_add,
      exec_pkg::op_lb,
      exec_pkg::op_lbu,
      exec_pkg::op_lh,
      exec_pkg::op_lhu,
      exec_pkg::op_lw,
      exec_pkg::op_sb,
      exec_pkg::op_sh,
      exec_pkg::op_sw: result = a + b; // effective address for memory ops.
      exec_pkg::op_sub: result = a - b;
      exec_pkg::op_and: result = a & b;
      exec_pkg::op_or: result = a | b;
      exec_pkg::op_xor: result = a ^ b;
      exec_pkg::op_sll: result = a << b[4:0];
      exec_pkg::op_srl: result = a >> b[4:0];
      exec_pkg::op_sra: result = exec_pkg::word_t'($signed(a) >>> b[4:0]);
      exec_pkg::op_slt: result = exec_pkg::word_t'($signed(a) < $signed(b));
      exec_pkg::op_sltu: result = exec_pkg::word_t'(a < b);
      exec_pkg::op_lui: result = b; // immediate already shifted by decode.
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- multiplier.sv
`default_nettype none

module multiplier (
  input wire clock,
  input wire reset,
  input wire start,
  input wire abort,
  input wire exec_pkg::word_t a,
  input wire exec_pkg::word_t b,
  input wire exec_pkg::op_t op,
  output logic ready,
  output exec_pkg::word_t result
);

  exec_pkg::iter_state_t state;
  exec_pkg::iter_cnt_t count;
  exec_pkg::word_t mcand;
  logic [2*exec_pkg::xlen-1:0] acc; // high half sums, low half holds multiplier.
  logic [exec_pkg::xlen:0] sum;
  logic high;

  // add the multiplicand when the current multiplier bit is set.
  assign sum = {1'b0, acc[2*exec_pkg::xlen-1:exec_pkg::xlen]} +
               (acc[0] ? {1'b0, mcand} : '0);

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state <= exec_pkg::iter_idle;
    end else if (abort) begin
      state <= exec_pkg::iter_idle;
    end else begin
      case (state)
        exec_pkg::iter_idle: if (start) state <= exec_pkg::iter_busy;
        exec_pkg::iter_busy: if (count == '0) state <= exec_pkg::iter_done;
        default: state <= exec_pkg::iter_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == exec_pkg::iter_idle && start) begin
      acc <= {{exec_pkg::xlen{1'b0}}, b};
      mcand <= a;
      high <= (op == exec_pkg::op_mulhu);
      count <= exec_pkg::iter_cnt_t'(exec_pkg::iter_count - 1);
    end else if (state == exec_pkg::iter_busy) begin
      acc <= {sum, acc[exec_pkg::xlen-1:1]}; // shift right one step.
      count <= count - 1'b1;
    end
  end

  assign ready = (state == exec_pkg::iter_done);
  assign result = high ? acc[2*exec_pkg::xlen-1:exec_pkg::xlen] : acc[exec_pkg::xlen-1:0];

endmodule

`default_nettype wire

//--- divider.sv
`default_nettype none

module divider (
  input wire clock,
  input wire reset,
  input wire start,
  input wire abort,
  input wire exec_pkg::word_t a,
  input wire exec_pkg::word_t b,
  input wire exec_pkg::op_t op,
  output logic ready,
  output exec_pkg::word_t result
);

  exec_pkg::iter_state_t state;
  exec_pkg::iter_cnt_t count;
  exec_pkg::word_t quot;
  exec_pkg::word_t rem;
  exec_pkg::word_t divisor;
  exec_pkg::word_t a_mag;
  exec_pkg::word_t b_mag;
  exec_pkg::word_t quot_fix;
  exec_pkg::word_t rem_fix;
  logic [exec_pkg::xlen:0] shifted;
  logic [exec_pkg::xlen:0] diff;
  logic is_signed;
  logic want_rem;
  logic quot_neg;
  logic rem_neg;
  logic div_zero;

  assign is_signed = (op == exec_pkg::op_div) || (op == exec_pkg::op_rem);
  assign a_mag = (is_signed && a[exec_pkg::xlen-1]) ? -a : a;
  assign b_mag = (is_signed && b[exec_pkg::xlen-1]) ? -b : b;

  // trial subtract of the divisor from the partial remainder.
  assign shifted = {rem, quot[exec_pkg::xlen-1]};
  assign diff = shifted - {1'b0, divisor};

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state <= exec_pkg::iter_idle;
    end else if (abort) begin
      state <= exec_pkg::iter_idle;
    end else begin
      case (state)
        exec_pkg::iter_idle: if (start) state <= exec_pkg::iter_busy;
        exec_pkg::iter_busy: if (count == '0) state <= exec_pkg::iter_done;
        default: state <= exec_pkg::iter_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == exec_pkg::iter_idle && start) begin
      quot <= a_mag;
      rem <= '0;
      divisor <= b_mag;
      want_rem <= (op == exec_pkg::op_rem) || (op == exec_pkg::op_remu);
      quot_neg <= is_signed && (a[exec_pkg::xlen-1] ^ b[exec_pkg::xlen-1]);
      rem_neg <= is_signed && a[exec_pkg::xlen-1]; // remainder takes the dividend sign.
      div_zero <= (b == '0);
      count <= exec_pkg::iter_cnt_t'(exec_pkg::iter_count - 1);
    end else if (state == exec_pkg::iter_busy) begin
      if (diff[exec_pkg::xlen] == 1'b0) begin
        rem <= diff[exec_pkg::xlen-1:0];
        quot <= {quot[exec_pkg::xlen-2:0], 1'b1};
      end else begin
        rem <= shifted[exec_pkg::xlen-1:0]; // restore.
        quot <= {quot[exec_pkg::xlen-2:0], 1'b0};
      end
      count <= count - 1'b1;
    end
  end

  // overflow falls out of the magnitudes, only x/0 needs a fixed quotient.
  assign quot_fix = div_zero ? '1 : (quot_neg ? -quot : quot);
  assign rem_fix = rem_neg ? -rem : rem;

  assign ready = (state == exec_pkg::iter_done);
  assign result = want_rem ? rem_fix : quot_fix;

endmodule

`default_nettype wire

//--- lsu.sv
`default_nettype none

module lsu (
  input wire exec_pkg::op_t op,
  input wire [1:0] addr_low,
  input wire exec_pkg::word_t store_data,
  input wire exec_pkg::word_t load_word,
  output exec_pkg::strb_t strb,
  output exec_pkg::word_t wdata_lanes,
  output exec_pkg::word_t load_data
);

  exec_pkg::word_t shifted;

  // store side. data goes to every lane, strobes pick the one written.
  always_comb begin
    strb = '0;
    wdata_lanes = store_data;
    case (op)
      exec_pkg::op_sb: begin
        strb = 4'b0001 << addr_low;
        wdata_lanes = {4{store_data[7:0]}};
      end
      exec_pkg::op_sh: begin
        strb = addr_low[1] ? 4'b1100 : 4'b0011;
        wdata_lanes = {2{store_data[15:0]}};
      end
      exec_pkg::op_sw: strb = 4'b1111;
      default: ;
    endcase
  end

  assign shifted = load_word >> {addr_low, 3'b000}; // addressed lane to bit 0.

  always_comb begin
    case (op)
      exec_pkg::op_lb: load_data = {{24{shifted[7]}}, shifted[7:0]};
      exec_pkg::op_lbu: load_data = {24'd0, shifted[7:0]};
      exec_pkg::op_lh: load_data = {{16{shifted[15]}}, shifted[15:0]};
      exec_pkg::op_lhu: load_data = {16'd0, shifted[15:0]};
      default: load_data = load_word;
    endcase
  end

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

module execute_stage (
  input wire clock,
  input wire reset,
  input wire flush,
  input wire in_valid,
  input wire exec_pkg::op_t in_op,
  input wire exec_pkg::word_t in_rs1,
  input wire exec_pkg::word_t in_rs2,
  input wire exec_pkg::word_t in_imm,
  input wire exec_pkg::reg_addr_t in_rd,
  input wire in_wren,
  output logic in_ready,
  output logic mem_req,
  output logic mem_we,
  output exec_pkg::word_t mem_addr,
  output exec_pkg::word_t mem_wdata,
  output exec_pkg::strb_t mem_strb,
  input wire exec_pkg::word_t mem_rdata,
  input wire mem_ready,
  output logic wb_valid,
  output exec_pkg::reg_addr_t wb_rd,
  output exec_pkg::word_t wb_data
);

  logic hold_valid;
  exec_pkg::op_t hold_op;
  exec_pkg::word_t hold_rs1;
  exec_pkg::word_t hold_rs2;
  exec_pkg::word_t hold_imm;
  exec_pkg::reg_addr_t hold_rd;
  logic hold_wren;

  exec_pkg::mem_state_t mem_state;
  exec_pkg::word_t alu_b;
  exec_pkg::word_t alu_result;
  exec_pkg::word_t mul_result;
  exec_pkg::word_t div_result;
  exec_pkg::word_t load_data;
  exec_pkg::word_t result_sel;
  logic accept;
  logic mul_start;
  logic div_start;
  logic mul_ready;
  logic div_ready;
  logic hold_alu;
  logic done;

  function automatic logic is_mul(input exec_pkg::op_t op);
    return op inside {exec_pkg::op_mul, exec_pkg::op_mulhu};
  endfunction

  function automatic logic is_div(input exec_pkg::op_t op);
    return op inside {exec_pkg::op_div, exec_pkg::op_divu, exec_pkg::op_rem, exec_pkg::op_remu};
  endfunction

  function automatic logic is_load(input exec_pkg::op_t op);
    return op inside {exec_pkg::op_lb, exec_pkg::op_lbu, exec_pkg::op_lh, exec_pkg::op_lhu,
                      exec_pkg::op_lw};
  endfunction

  function automatic logic is_store(input exec_pkg::op_t op);
    return op inside {exec_pkg::op_sb, exec_pkg::op_sh, exec_pkg::op_sw};
  endfunction

  // a held alu op retires this cycle, so the slot frees up at once.
  assign hold_alu = !(is_mul(hold_op) || is_div(hold_op) || is_load(hold_op) ||
                      is_store(hold_op));
  assign in_ready = !flush && (!hold_valid || hold_alu);
  assign accept = in_valid && in_ready;

  // iterative units latch their operands at acceptance.
  assign mul_start = accept && is_mul(in_op);
  assign div_start = accept && is_div(in_op);

  assign alu_b = (hold_op == exec_pkg::op_lui || is_load(hold_op) || is_store(hold_op)) ?
                 hold_imm : hold_rs2;

  alu alu_inst (
    .a(hold_rs1),
    .b(alu_b),
    .op(hold_op),
    .result(alu_result)
  );

  multiplier mul_inst (
    .clock(clock),
    .reset(reset),
    .start(mul_start),
    .abort(flush),
    .a(in_rs1),
    .b(in_rs2),
    .op(in_op),
    .ready(mul_ready),
    .result(mul_result)
  );

  divider div_inst (
    .clock(clock),
    .reset(reset),
    .start(div_start),
    .abort(flush),
    .a(in_rs1),
    .b(in_rs2),
    .op(in_op),
    .ready(div_ready),
    .result(div_result)
  );

  lsu lsu_inst (
    .op(hold_op),
    .addr_low(alu_result[1:0]),
    .store_data(hold_rs2),
    .load_word(mem_rdata),
    .strb(mem_strb),
    .wdata_lanes(mem_wdata),
    .load_data(load_data)
  );

  assign mem_req = (mem_state == exec_pkg::mem_wait_ready);
  assign mem_we = is_store(hold_op);
  assign mem_addr = alu_result; // fields stay put while the instruction is held.

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      mem_state <= exec_pkg::mem_idle;
    end else if (flush) begin
      mem_state <= exec_pkg::mem_idle;
    end else begin
      case (mem_state)
        exec_pkg::mem_idle:
          if (accept && (is_load(in_op) || is_store(in_op))) begin
            mem_state <= exec_pkg::mem_wait_ready;
          end
        default: if (mem_ready) mem_state <= exec_pkg::mem_idle;
      endcase
    end
  end

  assign done = hold_valid && (hold_alu ||
                               (is_mul(hold_op) && mul_ready) ||
                               (is_div(hold_op) && div_ready) ||
                               (mem_req && mem_ready));

  always_comb begin
    if (is_mul(hold_op)) begin
      result_sel = mul_result;
    end else if (is_div(hold_op)) begin
      result_sel = div_result;
    end else if (is_load(hold_op)) begin
      result_sel = load_data;
    end else begin
      result_sel = alu_result;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      hold_valid <= 1'b0;
    end else if (flush) begin
      hold_valid <= 1'b0; // drop whatever is in flight.
    end else if (accept) begin
      hold_valid <= 1'b1;
    end else if (done) begin
      hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      hold_op <= in_op;
      hold_rs1 <= in_rs1;
      hold_rs2 <= in_rs2;
      hold_imm <= in_imm;
      hold_rd <= in_rd;
      hold_wren <= in_wren;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= done && !flush && hold_wren && (hold_rd != '0) && !is_store(hold_op);
    end
  end

  always_ff @(posedge clock) begin
    if (done) begin
      wb_rd <= hold_rd;
      wb_data <= result_sel;
    end
  end

endmodule

`default_nettype wire

//--- execute_top.sv
`default_nettype none

module execute_top (
  input wire clock,
  input wire reset,
  input wire flush,
  input wire in_valid,
  input wire exec_pkg::op_t in_op,
  input wire exec_pkg::word_t in_rs1,
  input wire exec_pkg::word_t in_rs2,
  input wire exec_pkg::word_t in_imm,
  input wire exec_pkg::reg_addr_t in_rd,
  input wire in_wren,
  output logic in_ready,
  output logic mem_req,
  output logic mem_we,
  output exec_pkg::word_t mem_addr,
  output exec_pkg::word_t mem_wdata,
  output exec_pkg::strb_t mem_strb,
  input wire exec_pkg::word_t mem_rdata,
  input wire mem_ready,
  output logic wb_valid,
  output exec_pkg::reg_addr_t wb_rd,
  output exec_pkg::word_t wb_data
);

  // stage owns the alu, multiplier, divider and lsu.
  execute_stage stage_inst (
    .clock(clock),
    .reset(reset),
    .flush(flush),
    .in_valid(in_valid),
    .in_op(in_op),
    .in_rs1(in_rs1),
    .in_rs2(in_rs2),
    .in_imm(in_imm),
    .in_rd(in_rd),
    .in_wren(in_wren),
    .in_ready(in_ready),
    .mem_req(mem_req),
    .mem_we(mem_we),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_strb(mem_strb),
    .mem_rdata(mem_rdata),
    .mem_ready(mem_ready),
    .wb_valid(wb_valid),
    .wb_rd(wb_rd),
    .wb_data(wb_data)
  );

endmodule

`default_nettype wire

//--- exec_sva.sv
`default_nettype none

module exec_sva (
  input wire clock,
  input wire reset,
  input wire flush,
  input wire in_valid,
  input wire in_ready,
  input wire exec_pkg::op_t in_op,
  input wire mem_req,
  input wire mem_we,
  input wire exec_pkg::word_t mem_addr,
  input wire exec_pkg::word_t mem_wdata,
  input wire exec_pkg::strb_t mem_strb,
  input wire mem_ready,
  input wire wb_valid,
  input wire exec_pkg::reg_addr_t wb_rd
);

  int assert_fails = 0;

  // request fields hold until the memory answers.
  req_stable: assert property (@(posedge clock) disable iff (reset == 1'b0 || flush)
    mem_req && !mem_ready |=> mem_req && $stable(mem_we) && $stable(mem_addr) &&
      $stable(mem_wdata) && $stable(mem_strb))
  else begin
    assert_fails++;
    $error("memory request changed before mem_ready");
  end

  no_wb_to_zero: assert property (@(posedge clock) disable iff (reset == 1'b0)
    wb_valid |-> wb_rd != '0)
  else begin
    assert_fails++;
    $error("writeback to register zero");
  end

  stall_on_mem: assert property (@(posedge clock) disable iff (reset == 1'b0)
    mem_req |-> !in_ready)
  else begin
    assert_fails++;
    $error("in_ready high during a memory request");
  end

  // mul and div keep the stage busy for at least all their steps.
  stall_on_iter: assert property (@(posedge clock) disable iff (reset == 1'b0 || flush)
    in_valid && in_ready && (in_op inside {[exec_pkg::op_mul:exec_pkg::op_remu]}) |=>
      !in_ready [*exec_pkg::iter_count])
  else begin
    assert_fails++;
    $error("in_ready returned before the iterative unit finished");
  end

endmodule

bind execute_top exec_sva sva_inst (
  .clock(clock),
  .reset(reset),
  .flush(flush),
  .in_valid(in_valid),
  .in_ready(in_ready),
  .in_op(in_op),
  .mem_req(mem_req),
  .mem_we(mem_we),
  .mem_addr(mem_addr),
  .mem_wdata(mem_wdata),
  .mem_strb(mem_strb),
  .mem_ready(mem_ready),
  .wb_valid(wb_valid),
  .wb_rd(wb_rd)
);

`default_nettype wire

//--- exec_tb.sv
`default_nettype none

module exec_tb;

  typedef struct {
    string name;
    exec_pkg::op_t op;
    exec_pkg::word_t rs1;
    exec_pkg::word_t rs2;
    exec_pkg::word_t imm;
    exec_pkg::reg_addr_t rd;
    logic wren;
    exec_pkg::word_t exp_data;
    logic exp_write;
    exec_pkg::strb_t exp_strb;
    int stall; // extra memory wait cycles.
    int flush_after; // nonzero flushes this many cycles after acceptance.
  } row_t;

  localparam int row_count = 40;

  row_t rows [0:row_count-1] = '{
    '{"add", exec_pkg::op_add, 32'h5, 32'h7, '0, 5'd1, 1'b1, 32'hc, 1'b1, 4'h0, 0, 0},
    '{"sub", exec_pkg::op_sub, 32'h3, 32'h5, '0, 5'd2, 1'b1, 32'hfffffffe, 1'b1, 4'h0, 0, 0},
    '{"and", exec_pkg::op_and, 32'hf0f0f0f0, 32'hff00ff00, '0, 5'd3, 1'b1, 32'hf000f000, 1'b1,
      4'h0, 0, 0},
    '{"or", exec_pkg::op_or, 32'hf0f0f0f0, 32'h0f0f0000, '0, 5'd4, 1'b1, 32'hfffff0f0, 1'b1,
      4'h0, 0, 0},
    '{"xor", exec_pkg::op_xor, 32'haaaa5555, 32'hffff0000, '0, 5'd5, 1'b1, 32'h55555555, 1'b1,
      4'h0, 0, 0},
    '{"sll", exec_pkg::op_sll, 32'h3, 32'h24, '0, 5'd6, 1'b1, 32'h30, 1'b1, 4'h0, 0, 0},
    '{"srl", exec_pkg::op_srl, 32'h80000000, 32'h4, '0, 5'd7, 1'b1, 32'h08000000, 1'b1, 4'h0, 0, 0},
    '{"sra", exec_pkg::op_sra, 32'h80000000, 32'h4, '0, 5'd8, 1'b1, 32'hf8000000, 1'b1, 4'h0, 0, 0},
    '{"slt", exec_pkg::op_slt, '1, 32'h1, '0, 5'd9, 1'b1, 32'h1, 1'b1, 4'h0, 0, 0},
    '{"sltu", exec_pkg::op_sltu, '1, 32'h1, '0, 5'd10, 1'b1, 32'h0, 1'b1, 4'h0, 0, 0},
    '{"lui", exec_pkg::op_lui, 32'h99, '0, 32'h12345000, 5'd11, 1'b1, 32'h12345000, 1'b1,
      4'h0, 0, 0},
    '{"mul_neg", exec_pkg::op_mul, '1, '1, '0, 5'd12, 1'b1, 32'h1, 1'b1, 4'h0, 0, 0},
    '{"mulhu", exec_pkg::op_mulhu, '1, '1, '0, 5'd13, 1'b1, 32'hfffffffe, 1'b1, 4'h0, 0, 0},
    '{"div_neg", exec_pkg::op_div, 32'hfffffff9, 32'h2, '0, 5'd14, 1'b1, 32'hfffffffd, 1'b1,
      4'h0, 0, 0},
    '{"rem_neg", exec_pkg::op_rem, 32'hfffffff9, 32'h2, '0, 5'd15, 1'b1, '1, 1'b1, 4'h0, 0, 0},
    '{"divu", exec_pkg::op_divu, 32'hfffffff9, 32'h2, '0, 5'd16, 1'b1, 32'h7ffffffc, 1'b1,
      4'h0, 0, 0},
    '{"remu", exec_pkg::op_remu, 32'hfffffff9, 32'h2, '0, 5'd17, 1'b1, 32'h1, 1'b1, 4'h0, 0, 0},
    '{"div_zero", exec_pkg::op_div, 32'h5, '0, '0, 5'd18, 1'b1, '1, 1'b1, 4'h0, 0, 0},
    '{"rem_zero", exec_pkg::op_rem, 32'h5, '0, '0, 5'd19, 1'b1, 32'h5, 1'b1, 4'h0, 0, 0},
    '{"div_ovf", exec_pkg::op_div, 32'h80000000, '1, '0, 5'd20, 1'b1, 32'h80000000, 1'b1,
      4'h0, 0, 0},
    '{"rem_ovf", exec_pkg::op_rem, 32'h80000000, '1, '0, 5'd21, 1'b1, 32'h0, 1'b1, 4'h0, 0, 0},
    '{"rem_negdiv", exec_pkg::op_rem, 32'h7, 32'hfffffffe, '0, 5'd22, 1'b1, 32'h1, 1'b1,
      4'h0, 0, 0},
    '{"sw", exec_pkg::op_sw, 32'h40, 32'h11223344, '0, 5'd0, 1'b0, '0, 1'b0, 4'hf, 0, 0},
    '{"sh", exec_pkg::op_sh, 32'h40, 32'h0000aabb, 32'h2, 5'd0, 1'b0, '0, 1'b0, 4'hc, 0, 0},
    '{"sb", exec_pkg::op_sb, 32'h40, 32'h000000cc, 32'h1, 5'd7, 1'b1, '0, 1'b0, 4'h2, 0, 0},
    '{"lw", exec_pkg::op_lw, 32'h40, '0, '0, 5'd23, 1'b1, 32'haabbcc44, 1'b1, 4'h0, 0, 0},
    '{"lh", exec_pkg::op_lh, 32'h40, '0, 32'h2, 5'd24, 1'b1, 32'hffffaabb, 1'b1, 4'h0, 0, 0},
    '{"lhu", exec_pkg::op_lhu, 32'h40, '0, 32'h2, 5'd25, 1'b1, 32'h0000aabb, 1'b1, 4'h0, 0, 0},
    '{"lb", exec_pkg::op_lb, 32'h40, '0, 32'h1, 5'd26, 1'b1, 32'hffffffcc, 1'b1, 4'h0, 0, 0},
    '{"lbu", exec_pkg::op_lbu, 32'h40, '0, 32'h3, 5'd27, 1'b1, 32'h000000aa, 1'b1, 4'h0, 0, 0},
    '{"lh_low", exec_pkg::op_lh, 32'h40, '0, '0, 5'd28, 1'b1, 32'hffffcc44, 1'b1, 4'h0, 0, 0},
    '{"sw_stall", exec_pkg::op_sw, 32'h80, 32'h5555aaaa, 32'h4, 5'd0, 1'b0, '0, 1'b0, 4'hf, 12, 0},
    '{"lw_stall", exec_pkg::op_lw, 32'h80, '0, 32'h4, 5'd29, 1'b1, 32'h5555aaaa, 1'b1, 4'h0, 9, 0},
    '{"lw_fill", exec_pkg::op_lw, 32'h80, '0, 32'h10, 5'd30, 1'b1, 32'hc0de0024, 1'b1, 4'h0, 0, 0},
    '{"div_flushed", exec_pkg::op_div, 32'd100, 32'd7, '0, 5'd31, 1'b1, '0, 1'b0, 4'h0, 0, 5},
    '{"add_after_flush", exec_pkg::op_add, 32'h100, 32'h23, '0, 5'd1, 1'b1, 32'h123, 1'b1,
      4'h0, 0, 0},
    '{"add_rd_zero", exec_pkg::op_add, 32'h1, 32'h1, '0, 5'd0, 1'b1, '0, 1'b0, 4'h0, 0, 0},
    '{"add_no_wren", exec_pkg::op_add, 32'h1, 32'h1, '0, 5'd6, 1'b0, '0, 1'b0, 4'h0, 0, 0},
    '{"lw_rd_zero", exec_pkg::op_lw, 32'h40, '0, '0, 5'd0, 1'b1, '0, 1'b0, 4'h0, 0, 0},
    '{"mul_no_wren", exec_pkg::op_mul, 32'h3, 32'h3, '0, 5'd9, 1'b0, '0, 1'b0, 4'h0, 0, 0}
  };

  logic clock;
  logic reset;
  logic flush;
  logic in_valid;
  exec_pkg::op_t in_op;
  exec_pkg::word_t in_rs1;
  exec_pkg::word_t in_rs2;
  exec_pkg::word_t in_imm;
  exec_pkg::reg_addr_t in_rd;
  logic in_wren;
  logic in_ready;
  logic mem_req;
  logic mem_we;
  exec_pkg::word_t mem_addr;
  exec_pkg::word_t mem_wdata;
  exec_pkg::strb_t mem_strb;
  exec_pkg::word_t mem_rdata;
  logic mem_ready;
  logic wb_valid;
  exec_pkg::reg_addr_t wb_rd;
  exec_pkg::word_t wb_data;

  exec_pkg::word_t mem [0:63];
  integer seed;
  int extra_delay;
  int delay;
  logic pending;
  int cycle = 0;
  int pend_idx[$];
  int pend_cycle[$]; // -1 when the latency varies.

  execute_top dut (
    .clock(clock),
    .reset(reset),
    .flush(flush),
    .in_valid(in_valid),
    .in_op(in_op),
    .in_rs1(in_rs1),
    .in_rs2(in_rs2),
    .in_imm(in_imm),
    .in_rd(in_rd),
    .in_wren(in_wren),
    .in_ready(in_ready),
    .mem_req(mem_req),
    .mem_we(mem_we),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_strb(mem_strb),
    .mem_rdata(mem_rdata),
    .mem_ready(mem_ready),
    .wb_valid(wb_valid),
    .wb_rd(wb_rd),
    .wb_data(wb_data)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) cycle <= cycle + 1;

  task automatic fail_run();
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout: %s did not happen within 200 cycles", what);
    fail_run();
  endtask

  task automatic check_word(input string name, input exec_pkg::word_t exp,
                            input exec_pkg::word_t act);
    if (act !== exp) begin
      $display("mismatch %s: expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_rd(input string name, input exec_pkg::reg_addr_t exp,
                          input exec_pkg::reg_addr_t act);
    if (act !== exp) begin
      $display("mismatch %s: expected rd %0d actual rd %0d", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_strb(input string name, input exec_pkg::strb_t exp,
                            input exec_pkg::strb_t act);
    if (act !== exp) begin
      $display("mismatch %s: expected strobe %b actual strobe %b", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s: expected %b actual %b", name, exp, act);
      fail_run();
    end
  endtask

  function automatic logic alu_class(input exec_pkg::op_t op);
    return op <= exec_pkg::op_lui;
  endfunction

  function automatic logic runs_iterative(input exec_pkg::op_t op);
    return op >= exec_pkg::op_mul && op <= exec_pkg::op_remu;
  endfunction

  function automatic logic touches_memory(input exec_pkg::op_t op);
    return op >= exec_pkg::op_lb && op <= exec_pkg::op_sw;
  endfunction

  task automatic await_in_ready(input string what);
    int waited;
    waited = 0;
    while (in_ready !== 1'b1 && waited < 200) begin
      @(negedge clock);
      waited++;
    end
    if (in_ready !== 1'b1) timeout_fail({"in_ready for ", what});
  endtask

  task automatic drain_writebacks();
    int waited;
    waited = 0;
    while (pend_idx.size() != 0 && waited < 200) begin
      @(negedge clock);
      waited++;
    end
    if (pend_idx.size() != 0) timeout_fail("every expected writeback");
    repeat (5) @(negedge clock); // late strays show up here.
  endtask

  task automatic apply_row(input int i);
    string name;
    name = rows[i].name;
    await_in_ready(name);
    extra_delay = rows[i].stall;
    in_op = rows[i].op;
    in_rs1 = rows[i].rs1;
    in_rs2 = rows[i].rs2;
    in_imm = rows[i].imm;
    in_rd = rows[i].rd;
    in_wren = rows[i].wren;
    in_valid = 1'b1;
    @(negedge clock); // accepted at the rising edge in between.
    in_valid = 1'b0;
    if (rows[i].flush_after > 0) begin
      repeat (rows[i].flush_after - 1) @(negedge clock);
      flush = 1'b1;
      @(negedge clock);
      flush = 1'b0;
    end else begin
      if (rows[i].exp_write) begin
        pend_idx.push_back(i);
        pend_cycle.push_back(alu_class(rows[i].op) ? cycle + 1 : -1);
      end
      if (runs_iterative(rows[i].op)) begin
        check_flag({name, " in_ready after accept"}, 1'b0, in_ready);
        await_in_ready(name);
        check_flag({name, " wb_valid with in_ready"}, rows[i].exp_write, wb_valid);
      end else if (touches_memory(rows[i].op)) begin
        check_flag({name, " mem_req"}, 1'b1, mem_req);
        check_flag({name, " mem_we"}, rows[i].op >= exec_pkg::op_sb, mem_we);
        check_word({name, " mem_addr"}, rows[i].rs1 + rows[i].imm, mem_addr);
        check_strb(name, rows[i].exp_strb, mem_strb);
      end
    end
  endtask

  // writebacks are compared in order against the queue of expected rows.
  always @(negedge clock) begin : wb_monitor
    int idx;
    int due;
    if (reset == 1'b1 && wb_valid == 1'b1) begin
      if (pend_idx.size() == 0) begin
        $display("unexpected writeback to x%0d with data %h", wb_rd, wb_data);
        fail_run();
      end else begin
        idx = pend_idx.pop_front();
        due = pend_cycle.pop_front();
        check_rd(rows[idx].name, rows[idx].rd, wb_rd);
        check_word(rows[idx].name, rows[idx].exp_data, wb_data);
        if (due >= 0 && due != cycle) begin
          $display("mismatch %s: writeback cycle expected %0d actual %0d",
                   rows[idx].name, due, cycle);
          fail_run();
        end
      end
    end
  end

  always @(negedge clock) begin : memory_model
    if (reset == 1'b0) begin
      mem_ready = 1'b0;
      pending = 1'b0;
    end else if (mem_ready) begin
      mem_ready = 1'b0; // access completed at the last rising edge.
    end else if (mem_req) begin
      if (!pending) begin
        pending = 1'b1;
        delay = ($unsigned($random(seed)) % 4) + extra_delay;
      end
      if (delay == 0) begin
        mem_ready = 1'b1;
        mem_rdata = mem[mem_addr[7:2]];
        pending = 1'b0;
      end else begin
        delay--;
      end
    end
  end

  always @(posedge clock) begin : memory_write
    if (reset && mem_req && mem_ready && mem_we) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_strb[b]) mem[mem_addr[7:2]][8*b +: 8] = mem_wdata[8*b +: 8];
      end
    end
  end

  initial begin
    seed = 97;
    reset = 1'b0;
    flush = 1'b0;
    in_valid = 1'b0;
    in_op = exec_pkg::op_nop;
    in_rs1 = '0;
    in_rs2 = '0;
    in_imm = '0;
    in_rd = '0;
    in_wren = 1'b0;
    mem_rdata = '0;
    mem_ready = 1'b0;
    extra_delay = 0;
    pending = 1'b0;
    delay = 0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'hc0de0000 | i;
    end
    repeat (4) @(negedge clock);
    reset = 1'b1;
    check_flag("in_ready after reset", 1'b1, in_ready);
    check_flag("wb_valid after reset", 1'b0, wb_valid);
    check_flag("mem_req after reset", 1'b0, mem_req);
    for (int i = 0; i < row_count; i++) begin
      apply_row(i);
    end
    drain_writebacks();
    if (dut.sva_inst.assert_fails == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("%0d bound assertion failures", dut.sva_inst.assert_fails);
      fail_run();
    end
  end

endmodule

`default_nettype wire

//--- exec.f
exec_pkg.sv
alu.sv
multiplier.sv
divider.sv
lsu.sv
execute_stage.sv
execute_top.sv
exec_sva.sv
exec_tb.sv

//--- Bender.yml
package:
  name: exec

sources:
  - exec_pkg.sv
  - alu.sv
  - multiplier.sv
  - divider.sv
  - lsu.sv
  - execute_stage.sv
  - execute_top.sv
  - target: test
    files:
      - exec_sva.sv
      - exec_tb.sv
